//--- compile.f
+incdir+verilog
verilog/memBusPkg.sv
verilog/fetchPkg.sv
verilog/MemIc_GetOpLen.sv
verilog/MemIc_LineStore.sv
verilog/MemIc_FetchCtl.sv
verilog/MemIc_Top.sv
dv/tbMemIc.sv

//--- dv/tbMemIc.sv
`timescale 1ns/1ns
`include "memIc_settings.svh"

module tbMemIc;

	logic clock;
	logic rstN;
	logic reqValid;
	logic reqReady;
	fetchPkg::fetchReq_t req;
	logic respValid;
	logic respReady;
	fetchPkg::fetchResp_t resp;
	logic memReqValid;
	logic memReqReady;
	memBusPkg::memReq_t memReq;
	logic memRespValid;
	memBusPkg::memResp_t memResp;

	logic [15:0] stimLfsr = 16'd25;		// Opcode bits, modes, regions
	logic [15:0] stallLfsr = 16'd25;		// Memory ready stalls and delays
	int fillCount = 0;
	memBusPkg::lineAddr_t lastFill;
	int lastLatency;		// Negedges from accept to respValid

	// Prefix rows E0 to FF that decode as 64 bits
	localparam logic [31:0] wide64Rows = 32'h30F0CC00;

	MemIc_Top dut (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [15:0] galoisStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [15:0] takeBits(input bit stallStream, input int n);
		logic [15:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			if (stallStream) begin
				v = {v[14:0], stallLfsr[0]};
				stallLfsr = galoisStep(stallLfsr);
			end else begin
				v = {v[14:0], stimLfsr[0]};
				stimLfsr = galoisStep(stimLfsr);
			end
		end
		return v;
	endfunction

	function automatic logic [15:0] highMix(input logic [31:0] a);
		return {a[24:17], a[31:25], a[17]} ^ 16'hA5C3;		// Upper bits only
	endfunction

	function automatic logic [15:0] memHalf(input logic [31:0] a);
		return a[16:1] ^ highMix(a);
	endfunction

	// Inverts memHalf so that the halfword at the PC is op
	function automatic logic [31:0] pcForOp(input logic [15:0] op, input logic [13:0] region);
		logic [31:0] base;
		base = {1'b0, region, 17'h0};
		return {base[31:17], op ^ highMix(base), 1'b0};
	endfunction

	function automatic logic [`MEMIC_LINE_BITS-1:0] lineData(input memBusPkg::lineAddr_t la);
		logic [`MEMIC_LINE_BITS-1:0] d;
		int k;
		for (k = 0; k < `MEMIC_LINE_BITS / 16; k++) begin
			d[16*k +: 16] = memHalf({la, {`MEMIC_OFFS_BITS{1'b0}}} + 2 * k);
		end
		return d;
	endfunction

	function automatic int refHalfwords(input logic [15:0] op, input logic xg2, input logic rv);
		int hw;
		hw = 1;
		if (xg2 || (op[15:13] == 3'b111)) begin
			hw = (op[12:8] >= 5'd30) ? 6 : (wide64Rows[op[12:8]] ? 4 : 2);
		end else if ((op[15:12] == 4'h7) || (op[15:12] == 4'h9)) begin
			hw = op[11] ? 4 : 2;
		end
		if (rv) begin
			if (op[1:0] != 2'b11) begin
				hw = 1;
			end else if ((op[6:0] == 7'h1B) && (op[14:12] == 3'd4)) begin
				hw = 6;		// Jumbo
			end else begin
				hw = 2;
			end
		end
		return hw;
	endfunction

	function automatic logic [3:0] refCode(input int hw, input logic wxe);
		logic b3;
		logic b2;
		b3 = (hw == 6);
		b2 = (hw >= 4);
		return {b3, b2, b3 | (b2 & wxe), hw == 1};
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	// Memory model with one fill outstanding
	initial begin
		int delay;
		memBusPkg::lineAddr_t fillAddr;
		memReqReady = 1'b0;
		memRespValid = 1'b0;
		memResp = '0;
		forever begin
			@(posedge clock);
			#1;
			memReqReady = (takeBits(1, 2) != 0);		// Ready three cycles in four
			@(negedge clock);
			if (memReqValid && memReqReady) begin
				fillAddr = memReq.addr;
				@(posedge clock);
				#1;
				memReqReady = 1'b0;
				fillCount++;
				lastFill = fillAddr;
				delay = 1 + int'(takeBits(1, 2));
				repeat (delay) @(posedge clock);
				#1;
				memRespValid = 1'b1;
				memResp.data = lineData(fillAddr);
				@(posedge clock);
				#1;
				memRespValid = 1'b0;
			end
		end
	end

	task automatic runFetch(input logic [31:0] pc, input logic [2:0] mode, input int holdCycles,
			input int expFills);
		fetchPkg::fetchResp_t got;
		int fillsBefore;
		int waitCnt;
		int hw;
		int k;
		hw = refHalfwords(memHalf(pc), mode[2], mode[1]);
		fillsBefore = fillCount;
		@(posedge clock);
		#1;
		reqValid = 1'b1;
		req.pc = pc;
		req.mode = mode;
		respReady = (holdCycles == 0);
		waitCnt = 0;
		@(negedge clock);
		while (!reqReady) begin
			waitCnt++;
			if (waitCnt > 20) begin
				abortRun("The fetch request was never accepted");
			end
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		reqValid = 1'b0;
		waitCnt = 0;
		@(negedge clock);
		while (!respValid) begin
			waitCnt++;
			if (waitCnt > 200) begin
				abortRun("No fetch response arrived within 200 cycles");
			end
			@(negedge clock);
		end
		lastLatency = waitCnt;
		got = resp;
		assert (got.pc == pc) else
			abortRun($sformatf("Error at %0t ns: resp pc %h, expected %h", $time, got.pc, pc));
		for (k = 0; k < 6; k++) begin
			assert (got.istr[16*k +: 16] == memHalf(pc + 2 * k)) else
				abortRun($sformatf("Error at %0t ns: halfword %0d at pc %h is %h, expected %h",
					$time, k, pc, got.istr[16*k +: 16], memHalf(pc + 2 * k)));
		end
		assert (got.opLen == refCode(hw, mode[0])) else
			abortRun($sformatf("Error at %0t ns: opLen %b for op %h mode %b, expected %b",
				$time, got.opLen, memHalf(pc), mode, refCode(hw, mode[0])));
		assert (got.nextPc == pc + 2 * hw) else
			abortRun($sformatf("Error at %0t ns: nextPc %h for pc %h, expected %h",
				$time, got.nextPc, pc, pc + 2 * hw));
		if (expFills >= 0) begin
			assert (fillCount - fillsBefore == expFills) else
				abortRun($sformatf("Error at %0t ns: %0d memory requests for pc %h, expected %0d",
					$time, fillCount - fillsBefore, pc, expFills));
		end
		for (k = 0; k < holdCycles; k++) begin
			@(negedge clock);
			assert (respValid && !reqReady && (resp == got)) else
				abortRun($sformatf("Error at %0t ns: response not held under back-pressure",
					$time));
		end
		if (holdCycles > 0) begin
			@(posedge clock);
			#1;
			respReady = 1'b1;
		end
		@(posedge clock);		// Response taken here
		#1;
		respReady = 1'b0;
		@(negedge clock);
		assert (!respValid && reqReady) else
			abortRun($sformatf("Error at %0t ns: controller did not return to idle", $time));
	endtask

	initial begin
		logic [31:0] pcA;
		logic [15:0] op;
		logic [13:0] region;
		logic [2:0] mode;
		logic wxe;
		int row;
		int n;
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		respReady = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		rstN = 1'b1;
		@(negedge clock);
		assert (reqReady && !respValid && !memReqValid && !dut.lookValid) else
			abortRun($sformatf("Error at %0t ns: wrong handshake levels after reset", $time));

		// Fresh line fills once, the repeat hits in two cycles
		pcA = {15'h5555, 13'h0123, 4'h0};
		runFetch(pcA, 3'b000, 0, 1);
		assert (lastFill == pcA[31:4]) else
			abortRun($sformatf("Error at %0t ns: fill address %h, expected %h",
				$time, lastFill, pcA[31:4]));
		runFetch(pcA + 2, 3'b000, 0, 0);
		assert (lastLatency == 2) else
			abortRun($sformatf("Error at %0t ns: hit latency %0d, expected 2", $time, lastLatency));

		// Windows past a line end, the last one just fits
		runFetch({15'h5556, 13'h0456, 4'hE}, 3'b000, 0, 2);
		runFetch({15'h5557, 13'h0789, 4'h6}, 3'b100, 0, 2);
		runFetch({15'h5558, 13'h0ABC, 4'h4}, 3'b001, 0, 1);

		// Every prefix row in XG1 and XG2
		for (row = 0; row < 32; row++) begin
			region = 14'(takeBits(0, 14));
			wxe = (takeBits(0, 1) != 0);
			op = takeBits(0, 16);
			op[15:8] = {3'b111, row[4:0]};
			runFetch(pcForOp(op, region), {2'b00, wxe}, 0, -1);
			op[15:13] = 3'(takeBits(0, 3));		// XG2 ignores these
			runFetch(pcForOp(op, region + 1), {2'b10, wxe}, 0, -1);
		end

		// XG1 blocks 7 and 9, both widths
		for (n = 0; n < 4; n++) begin
			op = takeBits(0, 16);
			op[15:11] = {(n < 2) ? 4'h7 : 4'h9, n[0]};
			runFetch(pcForOp(op, 14'(takeBits(0, 14))), 3'b000, 0, -1);
		end

		// RISC-V compressed, 32-bit and jumbo
		for (n = 0; n < 9; n++) begin
			op = takeBits(0, 16);
			mode = 3'(takeBits(0, 3)) | 3'b010;
			if (n % 3 == 0) begin
				op[0] = 1'b0;
			end else begin
				op[1:0] = 2'b11;
				op[14:12] = (n % 3 == 1) ? 3'd2 : 3'd4;
				op[6:2] = (n % 3 == 1) ? op[6:2] : 5'b00110;
			end
			runFetch(pcForOp(op, 14'(takeBits(0, 14))), mode, 0, -1);
		end

		// Same 64-bit op without and with WXE
		pcA = pcForOp(16'hF5A7, 14'h2222);
		runFetch(pcA, 3'b000, 0, -1);
		runFetch(pcA, 3'b001, 0, 0);

		for (n = 0; n < 40; n++) begin
			region = 14'(takeBits(0, 14));
			mode = 3'(takeBits(0, 3));
			op = takeBits(0, 16);
			runFetch(pcForOp(op, region), mode, 0, -1);
		end

		runFetch(pcForOp(16'hFE31, 14'h0BAD), 3'b000, 5, -1);		// Held response

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tbMemIc -o simMemIc \
	&& ./obj_dir/simMemIc \
	|| { echo "Build or simulation failed"; exit 1; }

//--- verilog/MemIc_FetchCtl.sv
`timescale 1ns/1ns
`include "memIc_settings.svh"

module MemIc_FetchCtl (
	input logic clock,
	input logic rstN,
	input logic reqValid,
	output logic reqReady,
	input fetchPkg::fetchReq_t req,
	output logic respValid,
	input logic respReady,
	output fetchPkg::fetchResp_t resp,
	output logic lookValid,
	output memBusPkg::lineLookup_t look,
	input logic lookDone,
	input memBusPkg::lineResult_t result,
	output logic [15:0] opBits,
	output fetchPkg::decodeMode_t opMode,
	input logic [3:0] opLen
);

	fetchPkg::fetchState_e state;
	fetchPkg::fetchReq_t curReq;
	logic [`MEMIC_LINE_BITS-1:0] lineLo;		// Line holding the PC
	logic [`MEMIC_LINE_BITS-1:0] lineHi;		// Following line, crossing fetches only

	memBusPkg::lineAddr_t pcLine;
	logic [`MEMIC_OFFS_BITS-1:0] pcOffs;
	logic crossLine;
	logic [2*`MEMIC_LINE_BITS-1:0] lineCat;
	logic [`MEMIC_WINDOW_BITS-1:0] window;
	logic [2:0] halfCnt;
	logic [`MEMIC_ADDR_BITS-1:0] pcStep;

	assign pcLine = curReq.pc[`MEMIC_ADDR_BITS-1:`MEMIC_OFFS_BITS];
	assign pcOffs = curReq.pc[`MEMIC_OFFS_BITS-1:0];

	// Window end past the line end needs the next line too
	assign crossLine = (int'(pcOffs) + `MEMIC_WINDOW_BYTES) > `MEMIC_LINE_BYTES;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= fetchPkg::Idle;
		end else begin
			case (state)
				fetchPkg::Idle: begin
					if (reqValid) begin
						state <= fetchPkg::LookFirst;
					end
				end
				fetchPkg::LookFirst: begin
					if (lookDone && crossLine) begin
						state <= fetchPkg::LookSecond;
					end else if (lookDone) begin
						state <= fetchPkg::Emit;
					end
				end
				fetchPkg::LookSecond: begin
					if (lookDone) begin
						state <= fetchPkg::Emit;
					end
				end
				fetchPkg::Emit: begin
					if (respReady) begin
						state <= fetchPkg::Idle;
					end
				end
				default: begin
					state <= fetchPkg::Idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reqReady && reqValid) begin
			curReq <= req;
		end
		if (lookDone && (state == fetchPkg::LookFirst)) begin
			lineLo <= result.data;
		end
		if (lookDone && (state == fetchPkg::LookSecond)) begin
			lineHi <= result.data;
		end
	end

	assign reqReady = (state == fetchPkg::Idle);
	assign lookValid = (state == fetchPkg::LookFirst) || (state == fetchPkg::LookSecond);
	assign look.addr = (state == fetchPkg::LookSecond) ? pcLine + 1'b1 : pcLine;

	// lineHi only reaches the window when crossLine is set
	assign lineCat = {lineHi, lineLo};
	assign window = lineCat[{pcOffs, 3'b000} +: `MEMIC_WINDOW_BITS];

	assign opBits = window[15:0];
	assign opMode = curReq.mode;

	// Halfword count from the highest set bit of the code
	always_comb begin
		casez (opLen)
			4'b1???: begin
				halfCnt = 3'd6;
			end
			4'b01??: begin
				halfCnt = 3'd4;
			end
			4'b001?: begin
				halfCnt = 3'd2;
			end
			4'b0001: begin
				halfCnt = 3'd1;
			end
			default: begin
				halfCnt = 3'd2;		// 32-bit code loses bit 1 to the WXE rewrite
			end
		endcase
		pcStep = '0;
		pcStep[3:0] = {halfCnt, 1'b0};
	end

	assign respValid = (state == fetchPkg::Emit);
	assign resp.pc = curReq.pc;
	assign resp.istr = window;
	assign resp.opLen = opLen;
	assign resp.nextPc = curReq.pc + pcStep;

endmodule

//--- verilog/MemIc_GetOpLen.sv
`timescale 1ns/1ns
`include "memIc_settings.svh"

module MemIc_GetOpLen (
	input logic [15:0] istrBits,
	input logic isXG2,
	input logic isRV,
	input logic isWXE,
	output logic [3:0] opLen
);

	logic [3:0] baseLen;		// Code before the WXE rewrite
	logic isPrefix;			// Word sits in the E/F prefix block
	logic isXg1Wide;		// XG1 blocks 7 and 9 carry their own lengths

	// XG2 reuses bits 15:13 for registers, so only bit 12 picks E or F
	assign isPrefix = isXG2 || (istrBits[15:13] == 3'b111);
	assign isXg1Wide = !isXG2 && ((istrBits[15:12] == 4'h9) || (istrBits[15:12] == 4'h7));

	always_comb begin
		baseLen = fetchPkg::Len16;

		if (`def_true) begin
			if (isPrefix) begin
				casez (istrBits[12:9])
					4'b1111: begin
						baseLen = fetchPkg::Len96;		// FE, FF
					end
					4'b1110: begin
						baseLen = fetchPkg::Len64;		// FC, FD
					end
					4'b110?: begin
						baseLen = fetchPkg::Len32;		// F8 to FB
					end
					4'b101?: begin
						baseLen = fetchPkg::Len64;		// F4 to F7
					end
					4'b100?: begin
						baseLen = fetchPkg::Len32;		// F0 to F3
					end
					4'b0111: begin
						baseLen = fetchPkg::Len64;		// EE, EF
					end
					4'b0110: begin
						baseLen = fetchPkg::Len32;		// EC, ED
					end
					4'b0101: begin
						baseLen = fetchPkg::Len64;		// EA, EB
					end
					default: begin
						baseLen = fetchPkg::Len32;		// E0 to E9
					end
				endcase
			end else if (isXg1Wide) begin
				// Bit 11 selects the 64-bit form
				if (istrBits[11]) begin
					baseLen = fetchPkg::Len64;
				end else begin
					baseLen = fetchPkg::Len32;
				end
			end
		end

		if (`jx2_enable_riscv && isRV) begin
			if (istrBits[1:0] != 2'b11) begin
				baseLen = fetchPkg::Len16;		// Compressed
			end else begin
				baseLen = fetchPkg::Len32;
			end
			if (`jx2_enable_rvjumbo && (istrBits[6:0] == fetchPkg::RvOpJumbo) &&
					(istrBits[14:12] == 3'h4)) begin
				baseLen = fetchPkg::Len96;
			end
		end
	end

	// Bit 1 flags a bundle that is wider than its base op
	assign opLen = {baseLen[3:2], baseLen[3] | (baseLen[2] & isWXE), baseLen[0]};

endmodule

//--- verilog/MemIc_LineStore.sv
`timescale 1ns/1ns
`include "memIc_settings.svh"

module MemIc_LineStore (
	input logic clock,
	input logic rstN,
	input logic lookValid,
	input memBusPkg::lineLookup_t look,
	output logic lookDone,
	output memBusPkg::lineResult_t result,
	output logic memReqValid,
	input logic memReqReady,
	output memBusPkg::memReq_t memReq,
	input logic memRespValid,
	input memBusPkg::memResp_t memResp
);

	memBusPkg::storeState_e state;
	memBusPkg::lineAddr_t lookAddr;		// Held until lookDone
	logic [`MEMIC_INDEX_BITS-1:0] setIdx;
	logic [`MEMIC_TAG_BITS-1:0] lookTag;
	logic hit;

	logic [`MEMIC_SETS-1:0] setValid;
	logic [`MEMIC_TAG_BITS-1:0] tagArr [`MEMIC_SETS];
	logic [`MEMIC_LINE_BITS-1:0] dataArr [`MEMIC_SETS];

	assign setIdx = lookAddr[`MEMIC_INDEX_BITS-1:0];
	assign lookTag = lookAddr[`MEMIC_ADDR_BITS-`MEMIC_OFFS_BITS-1:`MEMIC_INDEX_BITS];
	assign hit = setValid[setIdx] && (tagArr[setIdx] == lookTag);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= memBusPkg::StoreIdle;
			setValid <= '0;
		end else begin
			case (state)
				memBusPkg::StoreIdle: begin
					if (lookValid) begin
						state <= memBusPkg::TagCheck;
					end
				end
				memBusPkg::TagCheck: begin
					if (hit) begin
						state <= memBusPkg::StoreIdle;		// Reported this cycle
					end else begin
						state <= memBusPkg::FillReq;
					end
				end
				memBusPkg::FillReq: begin
					if (memReqReady) begin
						state <= memBusPkg::FillWait;
					end
				end
				memBusPkg::FillWait: begin
					if (memRespValid) begin
						setValid[setIdx] <= 1'b1;
						state <= memBusPkg::Report;
					end
				end
				memBusPkg::Report: begin
					state <= memBusPkg::StoreIdle;
				end
				default: begin
					state <= memBusPkg::StoreIdle;
				end
			endcase
		end
	end

	// Lookup address and the arrays
	always_ff @(posedge clock) begin
		if ((state == memBusPkg::StoreIdle) && lookValid) begin
			lookAddr <= look.addr;
		end
		if ((state == memBusPkg::FillWait) && memRespValid) begin
			tagArr[setIdx] <= lookTag;
			dataArr[setIdx] <= memResp.data;
		end
	end

	// Hit reports straight from the check, a miss after the fill lands
	assign lookDone = ((state == memBusPkg::TagCheck) && hit) ||
		(state == memBusPkg::Report);

	assign result.addr = lookAddr;
	assign result.data = dataArr[setIdx];

	assign memReqValid = (state == memBusPkg::FillReq);
	assign memReq.addr = lookAddr;		// Stable while waiting on ready

endmodule

//--- verilog/MemIc_Top.sv
`timescale 1ns/1ns

module MemIc_Top (
	input logic clock,
	input logic rstN,
	input logic reqValid,
	output logic reqReady,
	input fetchPkg::fetchReq_t req,
	output logic respValid,
	input logic respReady,
	output fetchPkg::fetchResp_t resp,
	output logic memReqValid,
	input logic memReqReady,
	output memBusPkg::memReq_t memReq,
	input logic memRespValid,
	input memBusPkg::memResp_t memResp
);

	logic lookValid;
	logic lookDone;
	memBusPkg::lineLookup_t look;
	memBusPkg::lineResult_t result;
	logic [15:0] opBits;		// First halfword of the window
	fetchPkg::decodeMode_t opMode;
	logic [3:0] opLen;

	MemIc_FetchCtl fetchCtl (
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.req(req),
		.respValid(respValid),
		.respReady(respReady),
		.resp(resp),
		.lookValid(lookValid),
		.look(look),
		.lookDone(lookDone),
		.result(result),
		.opBits(opBits),
		.opMode(opMode),
		.opLen(opLen)
	);

	MemIc_LineStore lineStore (
		.clock(clock),
		.rstN(rstN),
		.lookValid(lookValid),
		.look(look),
		.lookDone(lookDone),
		.result(result),
		.memReqValid(memReqValid),
		.memReqReady(memReqReady),
		.memReq(memReq),
		.memRespValid(memRespValid),
		.memResp(memResp)
	);

	MemIc_GetOpLen opLenDec (
		.istrBits(opBits),
		.isXG2(opMode.isXG2),
		.isRV(opMode.isRV),
		.isWXE(opMode.isWXE),
		.opLen(opLen)
	);

endmodule

//--- verilog/fetchPkg.sv
`include "memIc_settings.svh"

package fetchPkg;

	typedef struct packed {
		logic isXG2;
		logic isRV;
		logic isWXE;		// Wide-execute bundles
	} decodeMode_t;

	typedef struct packed {
		logic [`MEMIC_ADDR_BITS-1:0] pc;		// Always halfword aligned
		decodeMode_t mode;
	} fetchReq_t;

	typedef struct packed {
		logic [`MEMIC_ADDR_BITS-1:0] pc;
		logic [`MEMIC_WINDOW_BITS-1:0] istr;		// First halfword in the low bits
		logic [3:0] opLen;
		logic [`MEMIC_ADDR_BITS-1:0] nextPc;
	} fetchResp_t;

	typedef enum logic [1:0] {
		Idle,
		LookFirst,
		LookSecond,
		Emit
	} fetchState_e;

	// Length codes as decoded, before bit 1 is rewritten
	typedef enum logic [3:0] {
		Len16 = 4'b0001,
		Len32 = 4'b0010,
		Len64 = 4'b0110,
		Len96 = 4'b1110
	} lenCode_e;

	// OP-IMM-32 major opcode; funct3 4 there marks a jumbo op
	typedef enum logic [6:0] {
		RvOpJumbo = 7'h1B
	} rvOpcode_e;

endpackage

//--- verilog/memBusPkg.sv
`include "memIc_settings.svh"

package memBusPkg;

	// Byte address with the line offset dropped
	typedef logic [`MEMIC_ADDR_BITS-`MEMIC_OFFS_BITS-1:0] lineAddr_t;

	typedef struct packed {
		lineAddr_t addr;		// Line to fill
	} memReq_t;

	typedef struct packed {
		logic [`MEMIC_LINE_BITS-1:0] data;		// Byte 0 in the low bits
	} memResp_t;

	typedef struct packed {
		lineAddr_t addr;
	} lineLookup_t;

	typedef struct packed {
		lineAddr_t addr;		// Echo of the lookup
		logic [`MEMIC_LINE_BITS-1:0] data;
	} lineResult_t;

	typedef enum logic [2:0] {
		StoreIdle,
		TagCheck,
		FillReq,
		FillWait,
		Report
	} storeState_e;

endpackage

//--- verilog/memIc_settings.svh
`ifndef MEMIC_SETTINGS_SVH
`define MEMIC_SETTINGS_SVH

`define MEMIC_ADDR_BITS		32		// Byte address width
`define MEMIC_LINE_BITS		128		// One cache line
`define MEMIC_SETS			16		// Direct-mapped sets

`define MEMIC_LINE_BYTES	(`MEMIC_LINE_BITS / 8)
`define MEMIC_OFFS_BITS		$clog2(`MEMIC_LINE_BYTES)
`define MEMIC_INDEX_BITS	$clog2(`MEMIC_SETS)
`define MEMIC_TAG_BITS		(`MEMIC_ADDR_BITS - `MEMIC_OFFS_BITS - `MEMIC_INDEX_BITS)

`define MEMIC_WINDOW_BITS	96		// Instruction text per fetch
`define MEMIC_WINDOW_BYTES	(`MEMIC_WINDOW_BITS / 8)

// Length decoder options, tested as values
`define def_true			1
`define jx2_enable_riscv	1
`define jx2_enable_rvjumbo	1

`endif
